// ==== Makefile ====
VERILATOR ?= verilator
TOP       := env_subsystem_tb
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/env_control.sv ====
// envelope control, adsr fsm with per-operator state file and slot context staging
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module env_control (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire [`OPL_OP_WIDTH-1:0] op_num,
    input wire opl_env_pkg::op_params_t params,
    input wire key_on,
    input wire key_off,
    input wire [`OPL_ENV_WIDTH-1:0] env_int_p0,     // stored attenuation, same op
    output logic [3:0] requested_rate,
    output opl_env_pkg::env_ctx_t ctx_p1,
    output opl_env_pkg::env_ctx_t ctx_p2
);
    import opl_env_pkg::*;

    env_state_t state_mem [`OPL_NUM_OPS];   // one state per operator
    env_state_t state_p0;
    env_state_t next_state;

    assign state_p0 = state_mem[op_num];

    always_comb begin
        case (state_p0)
            ATTACK:  next_state = (env_int_p0 == '0) ? DECAY : ATTACK;
            DECAY:   next_state = ({1'b0, params.sl} <= env_int_p0[8:4]) ? SUSTAIN : DECAY;
            SUSTAIN: next_state = params.egt ? SUSTAIN : RELEASE;
            default: next_state = RELEASE;  // release holds
        endcase

        // key pulses override the natural progression
        if (key_on)
            next_state = (env_int_p0 == '0) ? DECAY : ATTACK;
        else if (key_off)
            next_state = RELEASE;
    end

    // rate for the state this slot runs in
    always_comb begin
        case (next_state)
            ATTACK:  requested_rate = params.ar;
            DECAY:   requested_rate = params.dr;
            SUSTAIN: requested_rate = 4'd0;     // level frozen
            default: requested_rate = params.rr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OPL_NUM_OPS; i++)
                state_mem[i] <= RELEASE;
        end else if (sample_clk_en) begin
            state_mem[op_num] <= next_state;    // write back in strobe cycle
        end
    end

    // context pipe, only valid is cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            ctx_p1.valid <= 1'b0;
            ctx_p2.valid <= 1'b0;
        end else begin
            ctx_p1 <= '{valid: sample_clk_en, op: op_num, tl: params.tl,
                        am: params.am, state: next_state};
            ctx_p2 <= ctx_p1;
        end
    end

endmodule
`default_nettype wire

// ==== hdl/env_level_path.sv ====
// envelope level path, attenuation file, adsr update, level sum and clamp
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module env_level_path (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire [`OPL_OP_WIDTH-1:0] op_num,
    input wire [2:0] step_p1,
    input wire opl_env_pkg::env_ctx_t ctx_p1,
    input wire opl_env_pkg::env_ctx_t ctx_p2,
    input wire [`OPL_KSL_WIDTH-1:0] ksl_add_p1,
    input wire [`OPL_AM_WIDTH-1:0] am_val,
    output logic [`OPL_ENV_WIDTH-1:0] env_int_p0,
    output logic [`OPL_ENV_WIDTH-1:0] env,
    output logic env_valid,
    output logic [`OPL_OP_WIDTH-1:0] env_op
);
    import opl_env_pkg::*;

    logic [`OPL_ENV_WIDTH-1:0] att_mem [`OPL_NUM_OPS];
    logic [`OPL_ENV_WIDTH-1:0] env_int_p1;
    logic [`OPL_ENV_WIDTH-1:0] env_int_p2;     // updated, written back at p2
    logic [`OPL_KSL_WIDTH-1:0] ksl_add_p2;
    logic [11:0] att_scaled;                    // env * step
    logic [`OPL_ENV_WIDTH-1:0] att_dec;         // attack decrement
    logic [`OPL_ENV_WIDTH:0] att_inc;           // one spare bit for saturation
    logic [10:0] total_p2;

    assign env_int_p0 = att_mem[op_num];        // async read at p0

    always_comb begin
        att_scaled = {3'b000, env_int_p1} * {9'd0, step_p1};
        att_dec = att_scaled[11:3] + 9'd1;      // never exceeds env in attack
        att_inc = {1'b0, env_int_p1} + {7'd0, step_p1};
    end

    always_ff @(posedge clk) begin
        if (sample_clk_en)
            env_int_p1 <= env_int_p0;
        ksl_add_p2 <= ksl_add_p1;
        if (ctx_p1.valid) begin
            env_int_p2 <= env_int_p1;           // sustain, or attack with no step
            if (ctx_p1.state == ATTACK && step_p1 != 3'd0)
                env_int_p2 <= env_int_p1 - att_dec;     // exponential approach to 0
            else if (ctx_p1.state == DECAY || ctx_p1.state == RELEASE)
                env_int_p2 <= (att_inc > `OPL_SILENCE) ? `OPL_SILENCE : att_inc[8:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OPL_NUM_OPS; i++)
                att_mem[i] <= `OPL_SILENCE;
        end else if (ctx_p2.valid) begin
            att_mem[ctx_p2.op] <= env_int_p2;
        end
    end

    // env + tl*4 + ksl + tremolo, all non-negative
    assign total_p2 = {2'b00, env_int_p2} + {3'b000, ctx_p2.tl, 2'b00}
                    + {3'b000, ksl_add_p2} + (ctx_p2.am ? {6'd0, am_val} : 11'd0);

    always_ff @(posedge clk) begin
        env <= (total_p2 > 11'd511) ? `OPL_SILENCE : total_p2[8:0];    // clamp
        env_op <= ctx_p2.op;
        if (reset)
            env_valid <= 1'b0;
        else
            env_valid <= ctx_p2.valid;
    end

endmodule
`default_nettype wire

// ==== hdl/env_rate_counter.sv ====
// envelope rate counter, effective rate and per-operator accumulators giving the step count
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module env_rate_counter (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire [`OPL_OP_WIDTH-1:0] op_num,
    input wire [3:0] requested_rate,
    input wire opl_env_pkg::op_params_t params,
    input wire nts,
    output logic [2:0] step_p1          // attenuation steps for this slot
);
    logic [`OPL_RATE_ACC_WIDTH-1:0] acc_mem [`OPL_NUM_OPS];
    logic [3:0] key_scale;              // block*2 plus split bit
    logic [3:0] ks_adj;
    logic [6:0] rate_sum;               // up to 60 + 15
    logic [5:0] eff_rate;
    logic [17:0] acc_sum;               // accumulator plus increment, carry on top

    always_comb begin
        key_scale = {params.block, nts ? params.fnum[8] : params.fnum[9]};
        ks_adj = params.ksr ? key_scale : {2'b00, key_scale[3:2]};  // ksr off, quarter
        rate_sum = {1'b0, requested_rate, 2'b00} + {3'b000, ks_adj};

        if (requested_rate == 4'd0)
            eff_rate = 6'd0;
        else if (rate_sum > 7'd63)
            eff_rate = 6'd63;               // saturate
        else
            eff_rate = rate_sum[5:0];

        // increment 4..7, scaled by rate/4
        acc_sum = {3'b000, acc_mem[op_num]} + ({15'd0, 1'b1, eff_rate[1:0]} << eff_rate[5:2]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OPL_NUM_OPS; i++)
                acc_mem[i] <= '0;
        end else if (sample_clk_en && eff_rate < 6'd60) begin
            acc_mem[op_num] <= acc_sum[`OPL_RATE_ACC_WIDTH-1:0];    // keep low bits
        end
    end

    always_ff @(posedge clk) begin
        if (sample_clk_en) begin
            if (eff_rate >= 6'd60)
                step_p1 <= 3'd7;            // top rates, max step
            else
                step_p1 <= acc_sum[17:15];  // carry out
        end
    end

endmodule
`default_nettype wire

// ==== hdl/env_subsystem.sv ====
// opl envelope stage top, control fsm plus rate, level, ksl and tremolo datapath
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module env_subsystem (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,                   // one strobe per operator slot
    input wire [`OPL_OP_WIDTH-1:0] op_num,
    input wire opl_env_pkg::op_params_t params,
    input wire key_on,                          // pulse, with the strobe
    input wire key_off,
    input wire dam,                             // tremolo depth, chip-wide
    input wire nts,                             // keyboard split, chip-wide
    output logic [`OPL_ENV_WIDTH-1:0] env,
    output logic env_valid,                     // 3 cycles after the strobe
    output logic [`OPL_OP_WIDTH-1:0] env_op
);
    import opl_env_pkg::*;

    logic [`OPL_ENV_WIDTH-1:0] env_int_p0;      // stored attenuation of op_num
    logic [3:0] requested_rate;
    logic [2:0] step_p1;
    logic [`OPL_KSL_WIDTH-1:0] ksl_add_p1;
    logic [`OPL_AM_WIDTH-1:0] am_val;
    env_ctx_t ctx_p1;
    env_ctx_t ctx_p2;

    env_control env_control_inst (
        .clk(clk), .reset(reset), .sample_clk_en(sample_clk_en), .op_num(op_num),
        .params(params), .key_on(key_on), .key_off(key_off), .env_int_p0(env_int_p0),
        .requested_rate(requested_rate), .ctx_p1(ctx_p1), .ctx_p2(ctx_p2)
    );

    env_rate_counter env_rate_counter_inst (
        .clk(clk), .reset(reset), .sample_clk_en(sample_clk_en), .op_num(op_num),
        .requested_rate(requested_rate), .params(params), .nts(nts), .step_p1(step_p1)
    );

    env_level_path env_level_path_inst (
        .clk(clk), .reset(reset), .sample_clk_en(sample_clk_en), .op_num(op_num),
        .step_p1(step_p1), .ctx_p1(ctx_p1), .ctx_p2(ctx_p2), .ksl_add_p1(ksl_add_p1),
        .am_val(am_val), .env_int_p0(env_int_p0), .env(env), .env_valid(env_valid),
        .env_op(env_op)
    );

    ksl_add_rom ksl_add_rom_inst (
        .clk(clk), .params(params), .ksl_add_p1(ksl_add_p1)
    );

    tremolo tremolo_inst (
        .clk(clk), .reset(reset), .sample_clk_en(sample_clk_en), .op_num(op_num),
        .dam(dam), .am_val(am_val)
    );

endmodule
`default_nettype wire

// ==== hdl/ksl_add_rom.sv ====
// key-scale level attenuation from fnum and block, registered for p1
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module ksl_add_rom (
    input wire clk,
    input wire opl_env_pkg::op_params_t params,
    output logic [`OPL_KSL_WIDTH-1:0] ksl_add_p1
);
    import opl_env_pkg::*;

    logic [6:0] ksl_base;       // table entry, block 7
    logic [6:0] oct_drop;       // 8 per octave below block 7
    logic [6:0] ksl_diff;       // floored at 0, max 56

    always_comb begin
        ksl_base = ksl_table[params.fnum[9:6]];
        oct_drop = {1'b0, 3'd7 - params.block, 3'b000};
        if (ksl_base > oct_drop)
            ksl_diff = ksl_base - oct_drop;
        else
            ksl_diff = 7'd0;            // low notes get none
    end

    // ksl selects the slope
    always_ff @(posedge clk) begin
        case (params.ksl)
            2'd0:    ksl_add_p1 <= '0;
            2'd1:    ksl_add_p1 <= {1'b0, ksl_diff};
            2'd2:    ksl_add_p1 <= {ksl_diff, 1'b0};
            default: ksl_add_p1 <= {ksl_diff[5:0], 2'b00};  // bit 6 always 0 here
        endcase
    end

endmodule
`default_nettype wire

// ==== hdl/opl_env_defs.svh ====
// opl envelope stage shared widths, operator count and silence level
`ifndef OPL_ENV_DEFS_SVH
`define OPL_ENV_DEFS_SVH

// operators sharing the time-multiplexed envelope logic
`define OPL_NUM_OPS 18

// operator number, wide enough for 0..17
`define OPL_OP_WIDTH 5

// attenuation, 0 is loudest
`define OPL_ENV_WIDTH 9

// full attenuation
`define OPL_SILENCE 9'd511

// per-operator rate accumulator, carry above this width is the step count
`define OPL_RATE_ACC_WIDTH 15

// tremolo value, 0..26 at full depth
`define OPL_AM_WIDTH 5

// key-scale addend, largest table entry 56 shifted by 2 still fits
`define OPL_KSL_WIDTH 8

`endif

// ==== hdl/opl_env_pkg.sv ====
// opl envelope package with register fields, slot context, adsr states and ksl table
`default_nettype none
`include "opl_env_defs.svh"

package opl_env_pkg;

    // one-hot so the state file stays 4 bits per op
    typedef enum logic [3:0] {
        ATTACK  = 4'b0001,
        DECAY   = 4'b0010,
        SUSTAIN = 4'b0100,
        RELEASE = 4'b1000
    } env_state_t;

    // per-operator register fields, valid with the slot strobe
    typedef struct packed {
        logic [3:0] ar;     // attack rate
        logic [3:0] dr;     // decay rate
        logic [3:0] sl;     // sustain level, 16 attenuation steps each
        logic [3:0] rr;     // release rate
        logic [5:0] tl;     // total level
        logic ksr;          // key scale rate
        logic [1:0] ksl;    // key scale level
        logic egt;          // sustaining envelope
        logic am;           // tremolo on
        logic [9:0] fnum;
        logic [2:0] block;
    } op_params_t;

    // slot context carried down the pipe
    typedef struct packed {
        logic valid;
        logic [`OPL_OP_WIDTH-1:0] op;
        logic [5:0] tl;
        logic am;
        env_state_t state;  // state after this slot's update
    } env_ctx_t;

    // ksl attenuation by fnum[9:6], block 7
    localparam logic [6:0] ksl_table [16] = '{
        7'd0,  7'd24, 7'd32, 7'd37, 7'd40, 7'd43, 7'd45, 7'd47,
        7'd48, 7'd50, 7'd51, 7'd52, 7'd53, 7'd54, 7'd55, 7'd56
    };

endpackage
`default_nettype wire

// ==== hdl/tremolo.sv ====
// global tremolo, triangle position over 0..26 stepped once per frame, two depths
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module tremolo (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire [`OPL_OP_WIDTH-1:0] op_num,
    input wire dam,                         // 1 = deep
    output logic [`OPL_AM_WIDTH-1:0] am_val
);
    localparam logic [`OPL_AM_WIDTH-1:0] am_peak = 5'd26;

    logic [`OPL_AM_WIDTH-1:0] am_pos;       // triangle position
    logic going_down;

    // frame tick is the op 0 slot
    always_ff @(posedge clk) begin
        if (reset) begin
            am_pos <= '0;
            going_down <= 1'b0;
        end else if (sample_clk_en && op_num == '0) begin
            if (!going_down) begin
                if (am_pos == am_peak) begin
                    am_pos <= am_pos - 5'd1;    // turn at top
                    going_down <= 1'b1;
                end else begin
                    am_pos <= am_pos + 5'd1;
                end
            end else if (am_pos == '0) begin
                am_pos <= 5'd1;                 // turn at bottom
                going_down <= 1'b0;
            end else begin
                am_pos <= am_pos - 5'd1;
            end
        end
    end

    assign am_val = dam ? am_pos : {2'b00, am_pos[4:2]};    // shallow, quarter

endmodule
`default_nettype wire

// ==== test/env_subsystem_tb.sv ====
// envelope stage testbench checking a table of operator slots against a behavioral model
`timescale 1ns/1ns
`default_nettype none
`include "opl_env_defs.svh"

module env_subsystem_tb;
    import opl_env_pkg::*;

    localparam logic [1:0] k_none = 2'd0;
    localparam logic [1:0] k_on = 2'd1;
    localparam logic [1:0] k_off = 2'd2;
    localparam int num_rows = 15;

    typedef struct packed {
        logic [`OPL_OP_WIDTH-1:0] op;   // operator under test
        op_params_t p;
        logic dam;
        logic nts;
        logic [1:0] key;                // applied in the first frame only
        logic [7:0] frames;
        logic [`OPL_ENV_WIDTH-1:0] exp_env;     // env after the last frame
    } row_t;

    logic clk = 1'b0;
    logic reset;
    logic sample_clk_en;
    logic [`OPL_OP_WIDTH-1:0] op_num;
    op_params_t params;
    logic key_on;
    logic key_off;
    logic dam;
    logic nts;
    logic [`OPL_ENV_WIDTH-1:0] env;
    logic env_valid;
    logic [`OPL_OP_WIDTH-1:0] env_op;

    row_t rows [num_rows];
    env_state_t m_state [`OPL_NUM_OPS];     // model state per op
    int m_att [`OPL_NUM_OPS];
    int m_acc [`OPL_NUM_OPS];
    int tremolo_steps = 0;                  // op 0 strobes seen
    logic [31:0] rng_state = 32'h53253f43;
    logic [`OPL_ENV_WIDTH-1:0] row_env;     // last env of the row op
    int value_errors = 0;
    int timing_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 1000000;

    env_subsystem env_subsystem_inst (
        .clk(clk), .reset(reset), .sample_clk_en(sample_clk_en), .op_num(op_num),
        .params(params), .key_on(key_on), .key_off(key_off), .dam(dam), .nts(nts),
        .env(env), .env_valid(env_valid), .env_op(env_op)
    );

    always #10 clk = ~clk;     // 20 ns

    // hang guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("run stopped, no finish after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic op_params_t mk_par(input int ar, input int dr, input int sl, input int rr,
                                          input int tl, input int ksr, input int ksl,
                                          input int egt, input int am, input int fnum,
                                          input int block);
        return '{ar[3:0], dr[3:0], sl[3:0], rr[3:0], tl[5:0], ksr[0], ksl[1:0], egt[0], am[0],
                 fnum[9:0], block[2:0]};
    endfunction

    function automatic row_t mk_row(input int op, input op_params_t p, input int dam_i,
                                    input int nts_i, input logic [1:0] key, input int frames,
                                    input int exp_env);
        return '{op[4:0], p, dam_i[0], nts_i[0], key, frames[7:0], exp_env[8:0]};
    endfunction

    // reference model of one slot that advances the stored op state
    task automatic predict_slot(input int op, input op_params_t p, input logic kon,
                                input logic koff, input logic dam_i, input logic nts_i,
                                output int exp_env);
        env_state_t st;
        int att;
        int rate;
        int ks;
        int eff;
        int step;
        int ksl_v;
        int pos;
        int total;
        att = m_att[op];
        if (op == 0)
            tremolo_steps++;            // frame tick
        case (m_state[op])
            ATTACK:  st = (att == 0) ? DECAY : ATTACK;
            DECAY:   st = (att / 16 >= int'(p.sl)) ? SUSTAIN : DECAY;
            SUSTAIN: st = p.egt ? SUSTAIN : RELEASE;
            default: st = RELEASE;
        endcase
        if (kon)
            st = (att == 0) ? DECAY : ATTACK;
        else if (koff)
            st = RELEASE;
        m_state[op] = st;
        case (st)
            ATTACK:  rate = int'(p.ar);
            DECAY:   rate = int'(p.dr);
            SUSTAIN: rate = 0;
            default: rate = int'(p.rr);
        endcase
        ks = 2 * int'(p.block) + int'(nts_i ? p.fnum[8] : p.fnum[9]);
        if (!p.ksr)
            ks = ks / 4;
        eff = (rate == 0) ? 0 : 4 * rate + ks;
        if (eff > 63)
            eff = 63;
        if (eff >= 60) begin
            step = 7;
        end else begin
            m_acc[op] += (4 + eff % 4) << (eff / 4);
            step = m_acc[op] / 32768;   // carry above 15 bits
            m_acc[op] = m_acc[op] % 32768;
        end
        if (st == ATTACK && step != 0)
            att = att - (att * step / 8 + 1);
        else if (st == DECAY || st == RELEASE)
            att = (att + step > 511) ? 511 : att + step;
        m_att[op] = att;
        ksl_v = int'(ksl_table[p.fnum[9:6]]) - 8 * (7 - int'(p.block));
        if (ksl_v < 0 || p.ksl == 2'd0)
            ksl_v = 0;
        else
            ksl_v = ksl_v << (int'(p.ksl) - 1);
        pos = tremolo_steps % 52;       // triangle 0..26..0
        if (pos > 26)
            pos = 52 - pos;
        if (!dam_i)
            pos = pos / 4;
        total = att + 4 * int'(p.tl) + ksl_v + (p.am ? pos : 0);
        exp_env = (total > 511) ? 511 : total;
    endtask

    // strobe one slot, wait for env_valid, pad the slot to 5 cycles
    task automatic run_slot(input int op, input op_params_t p, input logic kon, input logic koff,
                            input logic dam_i, input logic nts_i,
                            output logic [`OPL_ENV_WIDTH-1:0] got);
        int exp_env;
        int n;
        predict_slot(op, p, kon, koff, dam_i, nts_i, exp_env);
        sample_clk_en = 1'b1;
        op_num = op[4:0];
        params = p;
        key_on = kon;
        key_off = koff;
        dam = dam_i;
        nts = nts_i;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
            if (n == 1) begin
                sample_clk_en = 1'b0;   // single-cycle strobe and key pulses
                key_on = 1'b0;
                key_off = 1'b0;
            end
        end while (!env_valid && n < 6);
        assert (env_valid) else begin
            $display("env_valid never came after the strobe of operator %0d", op);
            timing_errors++;
        end
        if (env_valid) begin
            assert (n == 3) else begin
                $display("env_valid came %0d cycles after the strobe of operator %0d", n, op);
                timing_errors++;
            end
            assert (env == exp_env[8:0]) else begin
                $display("ERROR env op %0d: got %h, expected %h", op, env, exp_env[8:0]);
                value_errors++;
            end
            assert (env_op == op[4:0]) else begin
                $display("ERROR env_op: got %h, expected %h", env_op, op[4:0]);
                value_errors++;
            end
        end
        got = env;
        while (n < 5) begin
            @(posedge clk);
            #2;
            n++;
            assert (!env_valid) else begin
                $display("env_valid still high %0d cycles after the strobe of operator %0d",
                         n, op);
                timing_errors++;
            end
        end
    endtask

    // one frame strobes ops 0..2 and the ops besides the row op get random fields
    task automatic run_frame(input row_t r, input bit first);
        op_params_t fp;
        logic [63:0] r64;
        logic [`OPL_ENV_WIDTH-1:0] got;
        int op;
        for (op = 0; op < 3; op++) begin
            if (op == int'(r.op)) begin
                run_slot(op, r.p, first && r.key == k_on, first && r.key == k_off,
                         r.dam, r.nts, got);
                row_env = got;
            end else begin
                r64 = {xorshift(), xorshift()};
                fp = r64[$bits(op_params_t)-1:0];
                run_slot(op, fp, 1'b0, 1'b0, r.dam, r.nts, got);
            end
        end
    endtask

    initial begin
        int r;
        int f;
        int total_frames;
        reset = 1'b1;
        sample_clk_en = 1'b0;
        op_num = '0;
        params = '0;
        key_on = 1'b0;
        key_off = 1'b0;
        dam = 1'b0;
        nts = 1'b0;
        for (r = 0; r < `OPL_NUM_OPS; r++) begin
            m_state[r] = RELEASE;
            m_att[r] = 511;
            m_acc[r] = 0;
        end
        // op, ar dr sl rr tl ksr ksl egt am fnum block, dam, nts, key, frames, env at end
        rows[0] = mk_row(1, mk_par(0, 0, 0, 0, 10, 0, 0, 1, 0, 0, 0), 0, 0, k_none, 2, 511);
        rows[1] = mk_row(1, mk_par(15, 0, 4, 0, 0, 0, 0, 1, 0, 0, 0), 0, 0, k_on, 3, 0);
        // decay by 2 per frame until held at sl 4
        rows[2] = mk_row(1, mk_par(15, 14, 4, 14, 0, 0, 0, 1, 0, 0, 0), 0, 0, k_none, 40, 64);
        rows[3] = mk_row(1, mk_par(15, 14, 4, 14, 0, 0, 0, 0, 0, 0, 0), 0, 0, k_none, 5, 74);
        rows[4] = mk_row(1, mk_par(15, 14, 4, 15, 0, 0, 0, 0, 0, 0, 0), 0, 0, k_off, 70, 511);
        rows[5] = mk_row(1, mk_par(15, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0), 0, 0, k_on, 3, 0);
        // low release rates with ksr on and nts 1 then ksr off and nts 0
        rows[6] = mk_row(1, mk_par(15, 0, 0, 10, 0, 1, 0, 1, 0, 'h100, 5), 0, 1, k_off, 8, 7);
        rows[7] = mk_row(1, mk_par(15, 0, 0, 10, 0, 0, 0, 1, 0, 'h200, 6), 0, 0, k_none, 8, 8);
        // total level and key scale
        rows[8] = mk_row(1, mk_par(15, 0, 0, 0, 40, 0, 1, 1, 0, 'h3c0, 7), 0, 0, k_none, 1, 224);
        rows[9] = mk_row(1, mk_par(15, 0, 0, 0, 40, 0, 2, 1, 0, 'h200, 6), 0, 0, k_none, 1, 248);
        rows[10] = mk_row(1, mk_par(15, 0, 0, 0, 40, 0, 3, 1, 0, 'h3c0, 7), 0, 0, k_none, 1, 392);
        rows[11] = mk_row(1, mk_par(15, 0, 0, 15, 63, 0, 3, 1, 0, 'h3c0, 7), 0, 0, k_none, 4, 511);
        rows[12] = mk_row(1, mk_par(15, 0, 0, 0, 0, 0, 2, 1, 0, 'h100, 1), 0, 0, k_none, 1, 36);
        // tremolo deep then shallow
        rows[13] = mk_row(1, mk_par(15, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0), 1, 0, k_none, 30, 57);
        rows[14] = mk_row(1, mk_par(15, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0), 0, 0, k_none, 20, 38);
        total_frames = 0;
        for (r = 0; r < num_rows; r++)
            total_frames += int'(rows[r].frames);
        cycle_limit = total_frames * 20 + 200;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!env_valid) else begin
            $display("env_valid high right after reset");
            timing_errors++;
        end
        for (r = 0; r < num_rows; r++) begin
            for (f = 0; f < int'(rows[r].frames); f++)
                run_frame(rows[r], f == 0);
            assert (row_env == rows[r].exp_env) else begin
                $display("ERROR env at end of row %0d: got %h, expected %h",
                         r, row_env, rows[r].exp_env);
                value_errors++;
            end
        end
        $display("value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors + timing_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/opl_env_pkg.sv
hdl/tremolo.sv
hdl/ksl_add_rom.sv
hdl/env_rate_counter.sv
hdl/env_level_path.sv
hdl/env_control.sv
hdl/env_subsystem.sv
test/env_subsystem_tb.sv
